// File: src/scroll_pkg.sv
// scroll renderer package: vector types, layer enum, geometry constants, cfg and write structs
package scroll_pkg;

    typedef logic [8:0]  vpos_t;       // line number
    typedef logic [8:0]  hpos_t;       // screen column
    typedef logic [15:0] scroll_t;     // scroll offset or vram base
    typedef logic [22:0] vram_addr_t;  // vram word address
    typedef logic [22:0] rom_addr_t;   // rom word address
    typedef logic [8:0]  pxl_t;        // {palette[4:0], colour[3:0]}
    typedef logic [8:0]  buf_addr_t;   // line store column

    // sequencer state, each layer value also picks the tile size
    typedef enum logic [1:0] {
        IDLE,
        L1,     // 8x8 tiles
        L2,     // 16x16 tiles
        L3      // 32x32 tiles
    } layer_e;

    localparam int   ACTIVE_START = 64;
    localparam int   ACTIVE_END   = 447;
    localparam int   LINE_PIXELS  = 384;
    localparam int   MAP_TILES    = 64;    // map is square
    localparam pxl_t BLANK_PXL    = 9'h1ff;

    typedef struct packed {
        scroll_t base;     // vram base, in 64-word units
        scroll_t hpos;
        scroll_t vpos;
    } layer_cfg_t;

    typedef struct packed {
        logic      we;
        layer_e    layer;
        buf_addr_t col;
        pxl_t      pxl;
    } buf_wr_t;

    // log2 of the tile size of a layer
    function automatic logic [2:0] tile_shift(input layer_e layer);
        case (layer)
            L2:      return 3'd4;
            L3:      return 3'd5;
            default: return 3'd3;
        endcase
    endfunction

endpackage

// File: src/tile_fetch.sv
// tile fetch FSM: map entry and tile row reads for one layer, pixel writes to the line store
`timescale 1ns/100ps

module tile_fetch import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  layer_e      layer,
    input  layer_cfg_t  cfg,
    input  vpos_t       vrender,
    output logic        done,
    output vram_addr_t  vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output buf_wr_t     buf_wr
);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_CODE,
    ST_ATTR,
    ST_ROM,
    ST_DRAW
} tile_fetch_st;

tile_fetch_st      st;
logic [2:0]        tshift;
logic [4:0]        tmask;
scroll_t           row_pix;
logic [5:0]        map_row;
logic [5:0]        tcol;       // map column of current tile
logic [4:0]        row_in;
logic [4:0]        hfine;
logic [1:0]        ck;
logic [1:0]        ck_last;
logic [1:0]        ck_eff;
logic [15:0]       code;
logic [5:0]        attr;       // flip in bit 5, palette below
logic [31:0]       rom_q;
logic [2:0]        px;
logic [2:0]        nib;
logic signed [9:0] col;        // screen column, negative for the first tile
vram_addr_t        map_addr;
rom_addr_t         chunk_addr;
logic              in_line;

always_comb begin
    tshift   = tile_shift(layer);
    tmask    = 5'((1 << tshift) - 1);
    row_pix  = cfg.vpos + scroll_t'(vrender);
    map_row  = 6'((row_pix >> tshift) % MAP_TILES);
    row_in   = row_pix[4:0] & tmask;
    hfine    = cfg.hpos[4:0] & tmask;
    ck_last  = 2'(tmask >> 3);          // groups per tile row minus one
    ck_eff   = attr[5] ? ck_last - ck : ck;
    nib      = attr[5] ? ~px : px;
    map_addr = vram_addr_t'({cfg.base, 6'd0}) + vram_addr_t'({map_row, tcol, 1'b0});
    chunk_addr = (rom_addr_t'(code) << (2 * tshift - 3))
               + (rom_addr_t'(row_in) << (tshift - 3))
               + rom_addr_t'(ck_eff);
    in_line  = col >= 0 && col < LINE_PIXELS;
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        st        <= ST_IDLE;
        done      <= 1'b0;
        vram_cs   <= 1'b0;
        rom_cs    <= 1'b0;
        buf_wr.we <= 1'b0;
        col       <= '0;
        tcol      <= '0;
        ck        <= '0;
        px        <= '0;
    end else begin
        done      <= 1'b0;
        buf_wr.we <= 1'b0;
        case (st)
            ST_IDLE: begin
                if (start) begin
                    col  <= -$signed({5'd0, hfine});
                    tcol <= 6'((cfg.hpos >> tshift) % MAP_TILES);
                    st   <= ST_CODE;
                end
            end
            ST_CODE: begin
                if (!vram_cs) begin
                    vram_cs   <= 1'b1;
                    vram_addr <= map_addr;
                end else if (vram_ok) begin
                    vram_cs <= 1'b0;
                    code    <= vram_data;
                    st      <= ST_ATTR;
                end
            end
            ST_ATTR: begin
                if (!vram_cs) begin
                    vram_cs   <= 1'b1;
                    vram_addr <= map_addr + 23'd1;   // attribute follows the code
                end else if (vram_ok) begin
                    vram_cs <= 1'b0;
                    attr    <= vram_data[5:0];
                    ck      <= '0;
                    st      <= ST_ROM;
                end
            end
            ST_ROM: begin
                if (!rom_cs) begin
                    rom_cs   <= 1'b1;
                    rom_addr <= chunk_addr;
                end else if (rom_ok) begin
                    rom_cs <= 1'b0;
                    rom_q  <= rom_data;
                    px     <= '0;
                    st     <= ST_DRAW;
                end
            end
            ST_DRAW: begin
                buf_wr.we    <= in_line;   // drop columns off screen
                buf_wr.layer <= layer;
                buf_wr.col   <= col[8:0];
                buf_wr.pxl   <= {attr[4:0], rom_q[{nib, 2'b00} +: 4]};
                col          <= col + 10'sd1;
                px           <= px + 3'd1;
                if (px == 3'd7) begin
                    if (ck != ck_last) begin
                        ck <= ck + 2'd1;
                        st <= ST_ROM;
                    end else if (col >= LINE_PIXELS - 1) begin
                        done <= 1'b1;
                        st   <= ST_IDLE;
                    end else begin
                        tcol <= tcol + 6'd1;     // wraps at the map edge
                        st   <= ST_CODE;
                    end
                end
            end
            default: st <= ST_IDLE;
        endcase
    end
end

// request held until the memory answers
a_vram_hold: assert property (@(posedge clk) disable iff (rst)
    vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr));

a_rom_hold: assert property (@(posedge clk) disable iff (rst)
    rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

// File: src/scroll_seq.sv
// layer sequencer: steps L1..L3 each line, latches layer cfg and drives the tile fetch
`timescale 1ns/100ps

module scroll_seq import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        line_start,
    input  vpos_t       vdump,
    input  layer_cfg_t  cfg1,
    input  layer_cfg_t  cfg2,
    input  layer_cfg_t  cfg3,
    output vram_addr_t  vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output buf_wr_t     buf_wr
);

layer_e     st;
layer_cfg_t cfg_q;
vpos_t      vrender;       // line being rendered, one ahead of vdump
logic       fetch_start;
logic       fetch_done;
logic       seq_done;

assign seq_done = fetch_done && st == L3;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        st          <= IDLE;
        fetch_start <= 1'b0;
    end else begin
        fetch_start <= 1'b0;
        if (line_start) begin
            st          <= L1;
            fetch_start <= 1'b1;
        end else if (seq_done) begin
            st <= IDLE;
        end else if (fetch_done) begin
            st          <= st == L1 ? L2 : L3;
            fetch_start <= 1'b1;
        end
    end
end

// layer registers, loaded one layer at a time
always_ff @(posedge clk) begin
    if (line_start) begin
        cfg_q   <= cfg1;
        vrender <= vdump + 9'd1;
    end else if (fetch_done && st == L1) begin
        cfg_q <= cfg2;
    end else if (fetch_done && st == L2) begin
        cfg_q <= cfg3;
    end
end

tile_fetch u_fetch (
    .clk       ( clk         ),
    .rst       ( rst         ),
    .start     ( fetch_start ),
    .layer     ( st          ),
    .cfg       ( cfg_q       ),
    .vrender   ( vrender     ),
    .done      ( fetch_done  ),
    .vram_addr ( vram_addr   ),
    .vram_cs   ( vram_cs     ),
    .vram_data ( vram_data   ),
    .vram_ok   ( vram_ok     ),
    .rom_addr  ( rom_addr    ),
    .rom_cs    ( rom_cs      ),
    .rom_data  ( rom_data    ),
    .rom_ok    ( rom_ok      ),
    .buf_wr    ( buf_wr      )
);

// all three layers must be done before the next line begins
a_line_idle: assert property (@(posedge clk) disable iff (rst)
    line_start |-> st == IDLE);

endmodule

// File: src/scan_ctrl.sv
// scan control: line start pulse, line store read column, bank select and active window
`timescale 1ns/100ps

module scan_ctrl import scroll_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    input  vpos_t     vdump,
    input  hpos_t     hdump,
    output logic      line_start,
    output buf_addr_t rd_addr,
    output logic      rd_bank,
    output logic      active
);

// column 0 of the line store sits at the left edge of the window
assign rd_addr = buf_addr_t'(hdump - hpos_t'(ACTIVE_START));

// even lines read bank 0, the fetch fills the other one
assign rd_bank = vdump[0];

assign active = hdump >= hpos_t'(ACTIVE_START) &&
                hdump <= hpos_t'(ACTIVE_END);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        line_start <= 1'b0;
    end else begin
        line_start <= pxl_cen && hdump == '0;   // once per line
    end
end

endmodule

// File: src/scroll_line_buf.sv
// double-buffered line stores for three layers with blanked output registers
`timescale 1ns/100ps

module scroll_line_buf import scroll_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  buf_wr_t   buf_wr,
    input  buf_addr_t rd_addr,
    input  logic      rd_bank,
    input  logic      active,
    output pxl_t      scr1_pxl,
    output pxl_t      scr2_pxl,
    output pxl_t      scr3_pxl
);

logic [9:0] wr_addr;
logic [9:0] rd_full;
logic       active_q;   // aligned with the memory read

assign wr_addr = {~rd_bank, buf_wr.col};
assign rd_full = {rd_bank, rd_addr};

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        active_q <= 1'b0;
    end else begin
        active_q <= active;
    end
end

for (genvar i = 0; i < 3; i++) begin : g_layer
    pxl_t mem [1024];
    pxl_t rd_q;
    pxl_t pxl_r;
    logic we;

    assign we = buf_wr.we && buf_wr.layer == layer_e'(i + 1);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= buf_wr.pxl;
        end
        rd_q <= mem[rd_full];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_r <= BLANK_PXL;
        end else begin
            pxl_r <= active_q ? rd_q : BLANK_PXL;   // blank outside the window
        end
    end
end

assign scr1_pxl = g_layer[0].pxl_r;
assign scr2_pxl = g_layer[1].pxl_r;
assign scr3_pxl = g_layer[2].pxl_r;

endmodule

// File: src/scroll_top.sv
// scroll renderer top: scan control, layer sequencer and line store
`timescale 1ns/100ps

module scroll_top import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  vpos_t       vdump,
    input  hpos_t       hdump,
    input  layer_cfg_t  cfg1,
    input  layer_cfg_t  cfg2,
    input  layer_cfg_t  cfg3,
    output vram_addr_t  vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output pxl_t        scr1_pxl,
    output pxl_t        scr2_pxl,
    output pxl_t        scr3_pxl
);

logic      line_start;
buf_addr_t rd_addr;
logic      rd_bank;
logic      active;
buf_wr_t   buf_wr;

scan_ctrl u_scan (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .pxl_cen    ( pxl_cen    ),
    .vdump      ( vdump      ),
    .hdump      ( hdump      ),
    .line_start ( line_start ),
    .rd_addr    ( rd_addr    ),
    .rd_bank    ( rd_bank    ),
    .active     ( active     )
);

scroll_seq u_seq (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .line_start ( line_start ),
    .vdump      ( vdump      ),
    .cfg1       ( cfg1       ),
    .cfg2       ( cfg2       ),
    .cfg3       ( cfg3       ),
    .vram_addr  ( vram_addr  ),
    .vram_cs    ( vram_cs    ),
    .vram_data  ( vram_data  ),
    .vram_ok    ( vram_ok    ),
    .rom_addr   ( rom_addr   ),
    .rom_cs     ( rom_cs     ),
    .rom_data   ( rom_data   ),
    .rom_ok     ( rom_ok     ),
    .buf_wr     ( buf_wr     )
);

scroll_line_buf u_buf (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .buf_wr     ( buf_wr     ),
    .rd_addr    ( rd_addr    ),
    .rd_bank    ( rd_bank    ),
    .active     ( active     ),
    .scr1_pxl   ( scr1_pxl   ),
    .scr2_pxl   ( scr2_pxl   ),
    .scr3_pxl   ( scr3_pxl   )
);

endmodule

// File: test/scroll_mem.sv
// VRAM and ROM models with hashed data and random ok delays
`timescale 1ns/100ps

module scroll_mem import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  vram_addr_t  vram_addr,
    input  logic        vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  rom_addr_t   rom_addr,
    input  logic        rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

logic [31:0] lfsr = 32'h1bcb_f44f;
logic [15:0] vram_q = '0;
logic        vram_ok_q = 1'b0;
logic [31:0] rom_q = '0;
logic        rom_ok_q = 1'b0;
logic [1:0]  vram_wait = '0;
logic [1:0]  rom_wait = '0;

assign vram_data = vram_q;
assign vram_ok   = vram_ok_q;
assign rom_data  = rom_q;
assign rom_ok    = rom_ok_q;

function automatic logic [15:0] vram_hash(input logic [22:0] a);
    logic [31:0] x;
    x = {9'd0, a} * 32'h9e37_79b1;
    return x[31:16] ^ x[15:0];
endfunction

function automatic logic [31:0] rom_hash(input logic [22:0] a);
    logic [31:0] x;
    x = {9'd0, a} * 32'h85eb_ca6b;
    return x ^ {15'd0, x[31:15]};
endfunction

// two LFSR bits, one step per bit
function automatic logic [1:0] next_delay();
    logic [1:0] b;
    b = '0;
    for (int i = 0; i < 2; i++) begin
        b    = {b[0], lfsr[0]};
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return b;
endfunction

always @(posedge clk) begin
    if (rst) begin
        vram_ok_q <= 1'b0;
        rom_ok_q  <= 1'b0;
    end else begin
        if (vram_cs && !vram_ok_q) begin
            if (vram_wait == 2'd0) begin
                vram_ok_q <= 1'b1;
                vram_q    <= vram_hash(vram_addr);
            end else begin
                vram_wait <= vram_wait - 2'd1;
            end
        end else begin
            vram_ok_q <= 1'b0;            // ok lasts one clock
            vram_wait <= next_delay();
        end
        if (rom_cs && !rom_ok_q) begin
            if (rom_wait == 2'd0) begin
                rom_ok_q <= 1'b1;
                rom_q    <= rom_hash(rom_addr);
            end else begin
                rom_wait <= rom_wait - 2'd1;
            end
        end else begin
            rom_ok_q <= 1'b0;
            rom_wait <= next_delay();
        end
    end
end

endmodule

// File: test/scroll_tb.sv
// scroll renderer testbench: clock, reset, line timing, reference pixel model and checks
`timescale 1ns/100ps

module scroll_tb import scroll_pkg::*; ();

localparam int FRAMES  = 3;
localparam int TIMEOUT = 3_500_000;   // clocks for all frames

logic        clk = 1'b0;
logic        rst = 1'b1;
logic        pxl_cen = 1'b0;
hpos_t       hdump = '0;
vpos_t       vdump = '0;
layer_cfg_t  cfg [3] = '{default: '0};
layer_cfg_t  shown_cfg [3] = '{default: '0};
int          shown_vr = 0;
logic        line_valid = 1'b0;
logic        started = 1'b0;
logic [2:0]  ph = '0;
int          frames = 0;
int          checks = 0;
int          flips = 0;
logic [31:0] lfsr = 32'h1bcb_f44f;
vram_addr_t  vram_addr;
logic        vram_cs;
logic [15:0] vram_data;
logic        vram_ok;
rom_addr_t   rom_addr;
logic        rom_cs;
logic [31:0] rom_data;
logic        rom_ok;
pxl_t        scr [3];

always #50 clk = ~clk;

scroll_top uut (
    .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .vdump(vdump), .hdump(hdump),
    .cfg1(cfg[0]), .cfg2(cfg[1]), .cfg3(cfg[2]),
    .vram_addr(vram_addr), .vram_cs(vram_cs), .vram_data(vram_data), .vram_ok(vram_ok),
    .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
    .scr1_pxl(scr[0]), .scr2_pxl(scr[1]), .scr3_pxl(scr[2])
);

scroll_mem u_mem (
    .clk(clk), .rst(rst),
    .vram_addr(vram_addr), .vram_cs(vram_cs), .vram_data(vram_data), .vram_ok(vram_ok),
    .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok)
);

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
endtask

task automatic report_mismatch(input string name, input pxl_t got, input pxl_t exp);
    $display("ERROR: %s got %h expected %h", name, got, exp);
    $display("Something failed");
    $fatal(1);
endtask

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] b;
    b = '0;
    for (int i = 0; i < n; i++) begin
        b    = {b[30:0], lfsr[0]};
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return b;
endfunction

// new layer registers, 16 LFSR bits per field
function automatic layer_cfg_t next_cfg();
    layer_cfg_t c;
    c.base = scroll_t'(rand_bits(16));
    c.hpos = scroll_t'(rand_bits(16));
    c.vpos = scroll_t'(rand_bits(16));
    return c;
endfunction

function automatic logic [15:0] vram_hash(input logic [22:0] a);
    logic [31:0] x;
    x = {9'd0, a} * 32'h9e37_79b1;
    return x[31:16] ^ x[15:0];
endfunction

function automatic logic [31:0] rom_hash(input logic [22:0] a);
    logic [31:0] x;
    x = {9'd0, a} * 32'h85eb_ca6b;
    return x ^ {15'd0, x[31:15]};
endfunction

// expected pixel of a layer with tile size 1 << sh at line column x
function automatic pxl_t exp_pxl(input int sh, input layer_cfg_t c, input int vr,
                                 input int x, output logic flip);
    int          t;
    int          sx;
    int          sy;
    int          p;
    int          ck;
    int          n;
    logic [22:0] va;
    logic [22:0] ra;
    logic [15:0] code;
    logic [15:0] attr;
    logic [31:0] w;
    t    = 1 << sh;
    sx   = int'(c.hpos) + x;
    sy   = int'(c.vpos) + vr;
    va   = 23'(int'(c.base) * 64 + (((sy >> sh) % 64) * 64 + (sx >> sh) % 64) * 2);
    code = vram_hash(va);
    attr = vram_hash(va + 23'd1);     // attribute word
    p    = sx % t;
    ck   = p / 8;
    n    = p % 8;
    flip = attr[5];
    if (flip) begin
        ck = t / 8 - 1 - ck;
        n  = 7 - n;
    end
    ra = 23'(int'(code) * t * (t / 8) + (sy % t) * (t / 8) + ck);
    w  = rom_hash(ra);
    return {attr[4:0], w[n * 4 +: 4]};
endfunction

// line timing and configuration stimulus
always @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 3; i++) begin
            cfg[i] <= next_cfg();
        end
    end else begin
        ph      <= ph + 3'd1;
        pxl_cen <= ph == 3'd6;
        if (pxl_cen) begin
            if (hdump == 9'd0) started <= 1'b1;
            if (hdump == 9'd511) begin
                hdump      <= '0;
                shown_cfg  <= cfg;        // render of the ending line is shown next
                shown_vr   <= int'(vdump) + 1;
                line_valid <= started;
                if (vdump == 9'd261) begin
                    vdump  <= '0;
                    frames <= frames + 1;
                    for (int i = 0; i < 3; i++) begin
                        cfg[i] <= next_cfg();
                    end
                end else begin
                    vdump <= vdump + 9'd1;
                end
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end
end

// pixel checks, sampled mid-way through each hdump
always @(posedge clk) begin : check
    int   x;
    pxl_t exp;
    logic flip;
    if (!rst && !started) begin
        assert (!vram_cs && !rom_cs) else report_failure("memory request before line start");
        for (int i = 0; i < 3; i++) begin
            assert (scr[i] == BLANK_PXL)
                else report_mismatch($sformatf("scr%0d_pxl", i + 1), scr[i], BLANK_PXL);
        end
    end
    if (!rst && ph == 3'd4) begin
        x = int'(hdump) - ACTIVE_START;
        for (int i = 0; i < 3; i++) begin
            if (x < 0 || x >= LINE_PIXELS) begin
                assert (scr[i] == BLANK_PXL)
                    else report_mismatch($sformatf("scr%0d_pxl", i + 1), scr[i], BLANK_PXL);
            end else if (line_valid) begin   // first shown bank was never rendered
                exp = exp_pxl(i + 3, shown_cfg[i], shown_vr, x, flip);
                checks <= checks + 1;
                if (flip) flips <= flips + 1;
                assert (scr[i] == exp)
                    else report_mismatch($sformatf("scr%0d_pxl", i + 1), scr[i], exp);
            end
        end
    end
    // no request may still be pending near the end of a line
    if (!rst && hdump >= 9'd500) begin
        assert (!vram_cs && !rom_cs) else report_failure("tile fetch busy at end of line");
    end
end

a_vram_stable: assert property (@(posedge clk) disable iff (rst)
    vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr))
    else report_failure("vram request changed before ok");

a_rom_stable: assert property (@(posedge clk) disable iff (rst)
    rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
    else report_failure("rom request changed before ok");

initial begin : run
    int cycles;
    cycles = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    while (frames < FRAMES && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles = cycles + 1;
    end
    if (frames >= FRAMES && checks > 0 && flips > 0) begin
        $display("Everything OK");
        $finish;
    end else begin
        report_failure("timeout or no flipped tile reached");
    end
end

endmodule

// File: scroll.f
src/scroll_pkg.sv
src/tile_fetch.sv
src/scroll_seq.sv
src/scan_ctrl.sv
src/scroll_line_buf.sv
src/scroll_top.sv
test/scroll_mem.sv
test/scroll_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the scroll renderer testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module scroll_tb -f scroll.f \
    --Mdir obj_dir -o scroll_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/scroll_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
